/* src/bus_pkg.sv */
package bus_pkg;

    // Low address byte source
    typedef enum logic [3:0] {
        addr_lo_ff,
        addr_lo_fe,
        addr_lo_fd,
        addr_lo_fc,
        addr_lo_fb,
        addr_lo_fa,
        addr_lo_pc,
        addr_lo_rbuf,
        addr_lo_rdata,
        addr_lo_alu,
        addr_lo_sp,
        addr_lo_hold
    } addr_lo_src_t;

    // High address byte source
    typedef enum logic [2:0] {
        addr_hi_01,
        addr_hi_00,
        addr_hi_ff,
        addr_hi_pc,
        addr_hi_rdata,
        addr_hi_alu,
        addr_hi_hold
    } addr_hi_src_t;

    typedef enum logic [1:0] {
        read_en_r,
        read_en_w,
        read_en_none
    } read_en_t;

    // Write byte source where none drives zero
    typedef enum logic [2:0] {
        wmem_none,
        wmem_pc_hi,
        wmem_pc_lo,
        wmem_status_bs,
        wmem_status_bc,
        wmem_store,
        wmem_rdata,
        wmem_alu
    } wmem_src_t;

    typedef enum logic [1:0] {
        store_a,
        store_x,
        store_y,
        store_status
    } store_reg_t;

    // Exclusive region upper bounds
    localparam logic [15:0] ram_limit = 16'h2000;
    localparam logic [15:0] ppu_limit = 16'h4000;
    localparam logic [15:0] io_limit  = 16'h4020;

    // Status byte layout NV1BDIZC
    localparam int status_n   = 7;
    localparam int status_v   = 6;
    localparam int status_one = 5;
    localparam int status_b   = 4;
    localparam int status_d   = 3;
    localparam int status_i   = 2;
    localparam int status_z   = 1;
    localparam int status_c   = 0;

    function automatic logic [7:0] status_byte(input logic n, v, b, d, i, z, c);
        logic [7:0] s;
        s             = 8'h00;
        s[status_n]   = n;
        s[status_v]   = v;
        s[status_one] = 1'b1;
        s[status_b]   = b;
        s[status_d]   = d;
        s[status_i]   = i;
        s[status_z]   = z;
        s[status_c]   = c;
        return s;
    endfunction

endpackage : bus_pkg

/* src/access_port.sv */
module access_port (
    input  logic clock,
    input  logic reset_n,
    input  logic req,
    input  logic done,
    output logic start,
    output logic ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_acked
    } state_t;

    state_t state;
    logic   req_q;

    // Request is registered once before it may launch an access
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            req_q <= 1'b0;
        end
        else begin
            req_q <= req;
        end
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            start <= 1'b0;
            ack   <= 1'b0;
        end
        else begin
            start <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_q) begin
                        start <= 1'b1;
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    // Wait for the memory stage to finish
                    if (done) begin
                        ack   <= 1'b1;
                        state <= st_acked;
                    end
                end
                st_acked: begin
                    // Hold ack until the requester lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ack only follows a completed access
    ack_after_done: assert property (
        @(posedge clock) disable iff (!reset_n)
        $rose(ack) |-> $past(done)
    );

    // One launch per handshake
    no_start_when_busy: assert property (
        @(posedge clock) disable iff (!reset_n)
        (state != st_idle) |=> !start
    );

endmodule : access_port

/* src/addr_gen.sv */
module addr_gen (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  start,
    input  logic                  fetch,
    input  bus_pkg::addr_lo_src_t lo_src,
    input  bus_pkg::addr_hi_src_t hi_src,
    input  bus_pkg::read_en_t     rw,
    input  bus_pkg::wmem_src_t    wsrc,
    input  bus_pkg::store_reg_t   store_sel,
    input  logic [7:0]            a,
    input  logic [7:0]            x,
    input  logic [7:0]            y,
    input  logic [7:0]            sp,
    input  logic [7:0]            r_buffer,
    input  logic [7:0]            alu_out,
    input  logic [7:0]            last_rdata,
    input  logic [15:0]           pc,
    input  logic                  n,
    input  logic                  v,
    input  logic                  d,
    input  logic                  i,
    input  logic                  z,
    input  logic                  c,
    output logic [15:0]           addr,
    output logic [7:0]            w_data,
    output bus_pkg::read_en_t     mem_rw,
    output logic                  mem_valid
);

    logic [7:0]        lo_next;
    logic [7:0]        hi_next;
    logic [7:0]        w_next;
    logic [7:0]        status_bs;
    logic [7:0]        status_bc;
    bus_pkg::read_en_t rw_next;

    assign status_bs = bus_pkg::status_byte(n, v, 1'b1, d, i, z, c);
    assign status_bc = bus_pkg::status_byte(n, v, 1'b0, d, i, z, c);

    // A held byte keeps its latch value
    always_comb begin
        lo_next = addr[7:0];
        hi_next = addr[15:8];
        rw_next = rw;
        if (fetch) begin
            lo_next = pc[7:0];
            if (hi_src == bus_pkg::addr_hi_rdata) begin
                hi_next = last_rdata;
            end
            else begin
                hi_next = pc[15:8];
            end
            rw_next = bus_pkg::read_en_r;
        end
        else begin
            case (lo_src)
                bus_pkg::addr_lo_ff:    lo_next = 8'hFF;
                bus_pkg::addr_lo_fe:    lo_next = 8'hFE;
                bus_pkg::addr_lo_fd:    lo_next = 8'hFD;
                bus_pkg::addr_lo_fc:    lo_next = 8'hFC;
                bus_pkg::addr_lo_fb:    lo_next = 8'hFB;
                bus_pkg::addr_lo_fa:    lo_next = 8'hFA;
                bus_pkg::addr_lo_pc:    lo_next = pc[7:0];
                bus_pkg::addr_lo_rbuf:  lo_next = r_buffer;
                bus_pkg::addr_lo_rdata: lo_next = last_rdata;
                bus_pkg::addr_lo_alu:   lo_next = alu_out;
                bus_pkg::addr_lo_sp:    lo_next = sp;
                default:                lo_next = addr[7:0];
            endcase
            case (hi_src)
                bus_pkg::addr_hi_01:    hi_next = 8'h01;
                bus_pkg::addr_hi_00:    hi_next = 8'h00;
                bus_pkg::addr_hi_ff:    hi_next = 8'hFF;
                bus_pkg::addr_hi_pc:    hi_next = pc[15:8];
                bus_pkg::addr_hi_rdata: hi_next = last_rdata;
                bus_pkg::addr_hi_alu:   hi_next = alu_out;
                default:                hi_next = addr[15:8];
            endcase
        end
    end

    always_comb begin
        case (wsrc)
            bus_pkg::wmem_pc_hi:     w_next = pc[15:8];
            bus_pkg::wmem_pc_lo:     w_next = pc[7:0];
            bus_pkg::wmem_status_bs: w_next = status_bs;
            bus_pkg::wmem_status_bc: w_next = status_bc;
            bus_pkg::wmem_store: begin
                case (store_sel)
                    bus_pkg::store_a: w_next = a;
                    bus_pkg::store_x: w_next = x;
                    bus_pkg::store_y: w_next = y;
                    // Pushed status always carries B
                    default:          w_next = status_bs;
                endcase
            end
            bus_pkg::wmem_rdata:     w_next = last_rdata;
            bus_pkg::wmem_alu:       w_next = alu_out;
            default:                 w_next = 8'h00;
        endcase
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            addr      <= 16'h0000;
            w_data    <= 8'h00;
            mem_rw    <= bus_pkg::read_en_none;
            mem_valid <= 1'b0;
        end
        else begin
            mem_valid <= start;
            if (start) begin
                addr   <= {hi_next, lo_next};
                w_data <= w_next;
                mem_rw <= rw_next;
            end
        end
    end

    addr_known: assert property (
        @(posedge clock) disable iff (!reset_n)
        mem_valid |-> !$isunknown(addr)
    );

endmodule : addr_gen

/* src/memory_map.sv */
module memory_map #(
    parameter int RAM_DEPTH  = 128,
    parameter int CART_DEPTH = 256
) (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              mem_valid,
    input  logic [15:0]       addr,
    input  logic [7:0]        w_data,
    input  bus_pkg::read_en_t mem_rw,
    output logic [7:0]        rdata,
    output logic              done
);

    localparam int RAM_AW  = $clog2(RAM_DEPTH);
    localparam int CART_AW = $clog2(CART_DEPTH);

    logic [7:0] ram      [RAM_DEPTH];
    logic [7:0] ppu_regs [8];
    logic [7:0] io_regs  [32];
    logic [7:0] cart     [CART_DEPTH];

    logic               in_ram;
    logic               in_ppu;
    logic               in_io;
    logic               is_read;
    logic               is_write;
    logic [RAM_AW-1:0]  ram_idx;
    logic [CART_AW-1:0] cart_idx;
    logic [7:0]         sel_byte;

    // Region checks are applied in priority order below
    assign in_ram = addr < bus_pkg::ram_limit;
    assign in_ppu = addr < bus_pkg::ppu_limit;
    assign in_io  = addr < bus_pkg::io_limit;

    // Mirrors fall out of the truncated indices
    assign ram_idx  = addr[RAM_AW-1:0];
    assign cart_idx = addr[CART_AW-1:0];

    assign is_read  = mem_valid && (mem_rw == bus_pkg::read_en_r);
    assign is_write = mem_valid && (mem_rw == bus_pkg::read_en_w);

    always_comb begin
        if (in_ram) begin
            sel_byte = ram[ram_idx];
        end
        else if (in_ppu) begin
            sel_byte = ppu_regs[addr[2:0]];
        end
        else if (in_io) begin
            sel_byte = io_regs[addr[4:0]];
        end
        else begin
            sel_byte = cart[cart_idx];
        end
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            ram      <= '{default: 8'h00};
            ppu_regs <= '{default: 8'h00};
            io_regs  <= '{default: 8'h00};
            cart     <= '{default: 8'h00};
        end
        else if (is_write) begin
            if (in_ram) begin
                ram[ram_idx] <= w_data;
            end
            else if (in_ppu) begin
                ppu_regs[addr[2:0]] <= w_data;
            end
            else if (in_io) begin
                io_regs[addr[4:0]] <= w_data;
            end
            else begin
                cart[cart_idx] <= w_data;
            end
        end
    end

    // rdata only moves on a read
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            rdata <= 8'h00;
            done  <= 1'b0;
        end
        else begin
            done <= mem_valid;
            if (is_read) begin
                rdata <= sel_byte;
            end
        end
    end

    single_valid: assert property (
        @(posedge clock) disable iff (!reset_n)
        mem_valid |=> !mem_valid
    );

endmodule : memory_map

/* src/cpu_bus_top.sv */
module cpu_bus_top #(
    parameter int RAM_DEPTH  = 128,
    parameter int CART_DEPTH = 256
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  req,
    input  logic                  fetch,
    input  bus_pkg::addr_lo_src_t lo_src,
    input  bus_pkg::addr_hi_src_t hi_src,
    input  bus_pkg::read_en_t     rw,
    input  bus_pkg::wmem_src_t    wsrc,
    input  bus_pkg::store_reg_t   store_sel,
    input  logic [7:0]            a,
    input  logic [7:0]            x,
    input  logic [7:0]            y,
    input  logic [7:0]            sp,
    input  logic [7:0]            r_buffer,
    input  logic [7:0]            alu_out,
    input  logic [15:0]           pc,
    input  logic                  n,
    input  logic                  v,
    input  logic                  d,
    input  logic                  i,
    input  logic                  z,
    input  logic                  c,
    output logic                  ack,
    output logic [7:0]            rdata,
    output logic [15:0]           addr,
    output logic [7:0]            w_data,
    output bus_pkg::read_en_t     mem_rw,
    output logic                  mem_valid
);

    logic start;
    logic done;

    access_port i_access_port (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req),
        .done    (done),
        .start   (start),
        .ack     (ack)
    );

    // Registered read data loops back as the last read data source
    addr_gen i_addr_gen (
        .clock      (clock),
        .reset_n    (reset_n),
        .start      (start),
        .fetch      (fetch),
        .lo_src     (lo_src),
        .hi_src     (hi_src),
        .rw         (rw),
        .wsrc       (wsrc),
        .store_sel  (store_sel),
        .a          (a),
        .x          (x),
        .y          (y),
        .sp         (sp),
        .r_buffer   (r_buffer),
        .alu_out    (alu_out),
        .last_rdata (rdata),
        .pc         (pc),
        .n          (n),
        .v          (v),
        .d          (d),
        .i          (i),
        .z          (z),
        .c          (c),
        .addr       (addr),
        .w_data     (w_data),
        .mem_rw     (mem_rw),
        .mem_valid  (mem_valid)
    );

    memory_map #(
        .RAM_DEPTH  (RAM_DEPTH),
        .CART_DEPTH (CART_DEPTH)
    ) i_memory_map (
        .clock     (clock),
        .reset_n   (reset_n),
        .mem_valid (mem_valid),
        .addr      (addr),
        .w_data    (w_data),
        .mem_rw    (mem_rw),
        .rdata     (rdata),
        .done      (done)
    );

endmodule : cpu_bus_top

/* verif/tb_cpu_bus_vectors.svh */
task automatic load_table();
    // Each row holds fill, fetch, lo_src, hi_src, rw, wsrc, store_sel,
    // a, x, y, sp, alu_out, pc, flags, expected addr and expected data
    // Expected data is rdata on reads and the write byte on writes
    // lo_src codes ff 0, fe 1, fd 2, fc 3, fb 4, fa 5, pc 6,
    // rbuf 7, rdata 8, alu 9, sp 10, hold 11
    // hi_src codes 01 0, 00 1, ff 2, pc 3, rdata 4, alu 5, hold 6
    // rw codes read 0, write 1, none 2
    // wsrc codes zero 0, pc hi 1, pc lo 2, status B set 3, B clear 4, store 5, rdata 6, alu 7
    // store_sel codes a 0, x 1, y 2, status 3
    // Flags are {n, v, d, i, z, c}

    // Every region reads zero out of reset
    add_row(1, 0, 0, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h0000, 'h00, 'h00ff, 'h00);
    add_row(0, 0, 4, 5, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h3f, 'h0000, 'h00, 'h3ffb, 'h00);
    add_row(0, 0, 10, 5, 0, 0, 0, 'h00, 'h00, 'h00, 'h1f, 'h40, 'h0000, 'h00, 'h401f, 'h00);
    add_row(1, 0, 1, 2, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h0000, 'h00, 'hfffe, 'h00);
    // RAM and its mirror
    add_row(0, 0, 9, 1, 1, 5, 0, 'h5a, 'h00, 'h00, 'h00, 'h42, 'h0000, 'h00, 'h0042, 'h5a);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h42, 'h0000, 'h00, 'h0042, 'h5a);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'hc2, 'h0000, 'h00, 'h00c2, 'h5a);
    // Video registers repeat every eight bytes
    add_row(0, 0, 10, 5, 1, 5, 1, 'h00, 'h3c, 'h00, 'h03, 'h20, 'h0000, 'h00, 'h2003, 'h3c);
    add_row(0, 0, 10, 5, 0, 0, 0, 'h00, 'h00, 'h00, 'h0b, 'h20, 'h0000, 'h00, 'h200b, 'h3c);
    add_row(0, 0, 4, 5, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h3f, 'h0000, 'h00, 'h3ffb, 'h3c);
    // I/O register and cartridge mirror
    add_row(0, 0, 10, 5, 1, 5, 2, 'h00, 'h00, 'h77, 'h10, 'h40, 'h0000, 'h00, 'h4010, 'h77);
    add_row(0, 0, 10, 5, 0, 0, 0, 'h00, 'h00, 'h00, 'h10, 'h40, 'h0000, 'h00, 'h4010, 'h77);
    add_row(0, 0, 10, 5, 1, 7, 0, 'h00, 'h00, 'h00, 'h05, 'h80, 'h0000, 'h00, 'h8005, 'h80);
    add_row(0, 0, 10, 5, 0, 0, 0, 'h00, 'h00, 'h00, 'h05, 'h81, 'h0000, 'h00, 'h8105, 'h80);
    // Constant bytes, hold and fetch
    add_row(1, 0, 2, 0, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h0000, 'h00, 'h01fd, 'h00);
    add_row(1, 0, 3, 2, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h0000, 'h00, 'hfffc, 'h00);
    add_row(1, 0, 5, 2, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h0000, 'h00, 'hfffa, 'h00);
    add_row(1, 0, 11, 6, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h0000, 'h00, 'hfffa, 'h00);
    add_row(1, 0, 11, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h0000, 'h00, 'h00fa, 'h00);
    add_row(0, 0, 6, 3, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h00c2, 'h00, 'h00c2, 'h5a);
    add_row(0, 1, 0, 0, 2, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h8105, 'h00, 'h8105, 'h80);
    add_row(0, 1, 0, 4, 2, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h1242, 'h00, 'h8042, 'h00);
    // Write byte sources, read back below
    add_row(0, 0, 9, 1, 1, 1, 0, 'h00, 'h00, 'h00, 'h00, 'h10, 'habcd, 'h00, 'h0010, 'hab);
    add_row(0, 0, 9, 1, 1, 2, 0, 'h00, 'h00, 'h00, 'h00, 'h11, 'habcd, 'h00, 'h0011, 'hcd);
    add_row(0, 0, 9, 1, 1, 3, 0, 'h00, 'h00, 'h00, 'h00, 'h12, 'h0000, 'h2b, 'h0012, 'hbb);
    add_row(0, 0, 9, 1, 1, 4, 0, 'h00, 'h00, 'h00, 'h00, 'h13, 'h0000, 'h14, 'h0013, 'h64);
    add_row(0, 0, 9, 1, 1, 5, 3, 'h00, 'h00, 'h00, 'h00, 'h14, 'h0000, 'h00, 'h0014, 'h30);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h11, 'h0000, 'h00, 'h0011, 'hcd);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h12, 'h0000, 'h00, 'h0012, 'hbb);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h13, 'h0000, 'h00, 'h0013, 'h64);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h14, 'h0000, 'h00, 'h0014, 'h30);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h10, 'h0000, 'h00, 'h0010, 'hab);
    add_row(0, 0, 9, 1, 1, 6, 0, 'h00, 'h00, 'h00, 'h00, 'h15, 'h0000, 'h00, 'h0015, 'hab);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h15, 'h0000, 'h00, 'h0015, 'hab);
    // Pointer byte steers the next address
    add_row(0, 0, 9, 1, 1, 5, 0, 'h80, 'h00, 'h00, 'h00, 'h30, 'h0000, 'h00, 'h0030, 'h80);
    add_row(0, 0, 9, 1, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h30, 'h0000, 'h00, 'h0030, 'h80);
    add_row(0, 0, 10, 4, 0, 0, 0, 'h00, 'h00, 'h00, 'h05, 'h00, 'h0000, 'h00, 'h8005, 'h80);
    add_row(1, 0, 8, 2, 0, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 'h0000, 'h00, 'hff80, 'h00);
endtask

/* verif/tb_cpu_bus.sv */
module tb_cpu_bus;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ram_depth  = 128;
    localparam int cart_depth = 256;
    // Cycles allowed for any single wait
    localparam int wait_limit = 40;

    typedef struct {
        bit                    fill;
        bit                    fetch;
        bus_pkg::addr_lo_src_t lo;
        bus_pkg::addr_hi_src_t hi;
        bus_pkg::read_en_t     rw;
        bus_pkg::wmem_src_t    ws;
        bus_pkg::store_reg_t   st;
        logic [7:0]            a;
        logic [7:0]            x;
        logic [7:0]            y;
        logic [7:0]            sp;
        logic [7:0]            alu;
        logic [15:0]           pc;
        logic [5:0]            flags;
        logic [15:0]           exp_addr;
        logic [7:0]            exp_data;
    } vector_t;

    logic                  clock;
    logic                  reset_n;
    logic                  req;
    logic                  fetch;
    bus_pkg::addr_lo_src_t lo_src;
    bus_pkg::addr_hi_src_t hi_src;
    bus_pkg::read_en_t     rw;
    bus_pkg::wmem_src_t    wsrc;
    bus_pkg::store_reg_t   store_sel;
    logic [7:0]            a, x, y, sp, r_buffer, alu_out;
    logic [15:0]           pc;
    logic                  n, v, d, i, z, c;
    logic                  ack;
    logic [7:0]            rdata;
    logic [15:0]           addr;
    logic [7:0]            w_data;
    bus_pkg::read_en_t     mem_rw;
    logic                  mem_valid;

    vector_t     vectors[$];
    logic [15:0] lfsr_state;
    int          error_count;
    int          test_count;

    cpu_bus_top #(
        .RAM_DEPTH  (ram_depth),
        .CART_DEPTH (cart_depth)
    ) i_cpu_bus_top (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] take_bits(input int count);
        logic [15:0] val;
        val = 16'h0000;
        for (int k = 0; k < count; k++) begin
            val        = {val[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    task automatic add_row(
        input int fill_v, fetch_v, lo_v, hi_v, rw_v, ws_v, st_v,
        input int a_v, x_v, y_v, sp_v, alu_v, pc_v, flags_v, addr_v, data_v
    );
        vector_t row;
        row.fill     = fill_v != 0;
        row.fetch    = fetch_v != 0;
        row.lo       = bus_pkg::addr_lo_src_t'(4'(lo_v));
        row.hi       = bus_pkg::addr_hi_src_t'(3'(hi_v));
        row.rw       = bus_pkg::read_en_t'(2'(rw_v));
        row.ws       = bus_pkg::wmem_src_t'(3'(ws_v));
        row.st       = bus_pkg::store_reg_t'(2'(st_v));
        row.a        = 8'(a_v);
        row.x        = 8'(x_v);
        row.y        = 8'(y_v);
        row.sp       = 8'(sp_v);
        row.alu      = 8'(alu_v);
        row.pc       = 16'(pc_v);
        row.flags    = 6'(flags_v);
        row.exp_addr = 16'(addr_v);
        row.exp_data = 8'(data_v);
        vectors.push_back(row);
    endtask

    `include "tb_cpu_bus_vectors.svh"

    task automatic check_value(input string what, input logic [15:0] got, expected);
        if (got !== expected) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    // Filler rows get random register values, none of which affect the result
    task automatic drive_row(input vector_t row);
        if (row.fill) begin
            row.a     = 8'(take_bits(8));
            row.x     = 8'(take_bits(8));
            row.y     = 8'(take_bits(8));
            row.sp    = 8'(take_bits(8));
            row.alu   = 8'(take_bits(8));
            row.pc    = take_bits(16);
            row.flags = 6'(take_bits(6));
        end
        @(posedge clock);
        fetch              <= row.fetch;
        lo_src             <= row.lo;
        hi_src             <= row.hi;
        rw                 <= row.rw;
        wsrc               <= row.ws;
        store_sel          <= row.st;
        a                  <= row.a;
        x                  <= row.x;
        y                  <= row.y;
        sp                 <= row.sp;
        alu_out            <= row.alu;
        pc                 <= row.pc;
        {n, v, d, i, z, c} <= row.flags;
        r_buffer           <= 8'(take_bits(8));
        req                <= 1'b1;
    endtask

    // Sample at falling edges until ack reaches the level
    task automatic wait_ack(input logic level, output bit ok);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (ack !== level && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        ok = (ack === level);
    endtask

    initial begin
        bit                ok;
        int                errors_before;
        bus_pkg::read_en_t exp_rw;
        reset_n                               <= 1'b0;
        req                                   <= 1'b0;
        fetch                                 <= 1'b0;
        lo_src                                <= bus_pkg::addr_lo_hold;
        hi_src                                <= bus_pkg::addr_hi_hold;
        rw                                    <= bus_pkg::read_en_none;
        wsrc                                  <= bus_pkg::wmem_none;
        store_sel                             <= bus_pkg::store_a;
        {a, x, y, sp, r_buffer, alu_out}      <= '0;
        pc                                    <= 16'h0000;
        {n, v, d, i, z, c}                    <= 6'b000000;
        lfsr_state  = 16'd27;
        error_count = 0;
        test_count  = 0;
        load_table();
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_value("ack after reset", 16'(ack), 16'h0000);
        foreach (vectors[k]) begin
            errors_before = error_count;
            // Fetch mode always reads
            exp_rw = vectors[k].rw;
            if (vectors[k].fetch) begin
                exp_rw = bus_pkg::read_en_r;
            end
            drive_row(vectors[k]);
            wait_ack(1'b1, ok);
            if (!ok) begin
                $display("Test %0d: ack did not rise within %0d cycles", k, wait_limit);
                error_count++;
            end
            else begin
                check_value("addr", addr, vectors[k].exp_addr);
                check_value("mem_rw", 16'(mem_rw), 16'(exp_rw));
                if (exp_rw == bus_pkg::read_en_r) begin
                    check_value("rdata", 16'(rdata), 16'(vectors[k].exp_data));
                end
                else if (exp_rw == bus_pkg::read_en_w) begin
                    check_value("w_data", 16'(w_data), 16'(vectors[k].exp_data));
                end
                // Requester stalls here so ack stays up and nothing relaunches
                repeat (2) begin
                    @(negedge clock);
                    check_value("ack while req held", 16'(ack), 16'h0001);
                    check_value("mem_valid while req held", 16'(mem_valid), 16'h0000);
                end
            end
            @(posedge clock);
            req <= 1'b0;
            wait_ack(1'b0, ok);
            if (!ok) begin
                $display("Test %0d: ack did not fall within %0d cycles", k, wait_limit);
                error_count++;
            end
            test_count++;
            $display("Test %0d at %h: %s", k, vectors[k].exp_addr,
                     (error_count == errors_before) ? "ok" : "FAILED");
        end
        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end
        else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_cpu_bus

/* flist.f */
+incdir+verif
src/bus_pkg.sv
src/access_port.sv
src/addr_gen.sv
src/memory_map.sv
src/cpu_bus_top.sv
verif/tb_cpu_bus.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_bus
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Fails unless the simulation prints the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
